// ==== common/arm_isa_pkg.sv ====
`default_nettype none

package arm_isa_pkg;

    // Data-processing opcodes, ARM field values.
    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_EOR = 4'b0001,
        OP_SUB = 4'b0010,
        OP_ADD = 4'b0100,
        OP_CMP = 4'b1010,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101,
        OP_MVN = 4'b1111
    } op_e;

    typedef enum logic [3:0] {
        COND_EQ = 4'b0000,
        COND_NE = 4'b0001,
        COND_AL = 4'b1110,
        COND_NV = 4'b1111   // Never true, used by the no-op word.
    } cond_e;

    typedef enum logic [1:0] {
        CLASS_DP  = 2'b00,
        CLASS_MEM = 2'b01,  // S bit set means LDR.
        CLASS_BR  = 2'b10
    } instr_class_e;

    typedef struct packed {
        cond_e        cond;
        instr_class_e cls;
        logic         i;          // Immediate second operand.
        op_e          opcode;
        logic         s;
        logic [3:0]   rn;
        logic [3:0]   rd;
        logic [11:0]  operand2;   // imm8, or shift_imm[11:7] and rm[3:0].
    } dp_word_t;

    typedef struct packed {
        cond_e        cond;
        instr_class_e cls;
        logic         rsvd;       // Set to 1 in branch words.
        logic         link;
        logic [23:0]  imm24;
    } br_word_t;

    typedef union packed {
        dp_word_t dp;
        br_word_t br;
    } instr_u;

    typedef enum logic [3:0] {
        EXE_NOP = 4'b0000,
        EXE_MOV = 4'b0001,
        EXE_ADD = 4'b0010,
        EXE_SUB = 4'b0100,
        EXE_AND = 4'b0110,
        EXE_ORR = 4'b0111,
        EXE_EOR = 4'b1000,
        EXE_MVN = 4'b1001
    } exe_cmd_e;

    localparam logic [31:0] NOP_WORD = 32'hF000_0000;

endpackage

`default_nettype wire

// ==== common/arm_pipe_pkg.sv ====
`default_nettype none

package arm_pipe_pkg;

    import arm_isa_pkg::*;

    typedef enum logic [1:0] {
        FWD_RF  = 2'b00,
        FWD_MEM = 2'b01,
        FWD_WB  = 2'b10
    } fwd_sel_e;

    // Decode/execute register.
    typedef struct packed {
        logic [31:0] pc;          // Address of the instruction itself.
        logic [31:0] val_rn;
        logic [31:0] val_rm;
        logic [3:0]  src1;
        logic [3:0]  src2;
        logic [3:0]  dest;
        exe_cmd_e    exe_cmd;
        logic        imm;
        logic [11:0] shift_operand;
        logic [23:0] signed_imm_24;
        logic        wb_en;
        logic        mem_r_en;
        logic        mem_w_en;
        logic        b;
        logic        s;
    } id_ex_t;

    typedef struct packed {
        logic [31:0] alu_res;
        logic [31:0] val_rm;      // Store data.
        logic [3:0]  dest;
        logic        wb_en;
        logic        mem_r_en;
        logic        mem_w_en;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] alu_res;
        logic [31:0] mem_res;
        logic [3:0]  dest;
        logic        wb_en;
        logic        mem_r_en;
    } mem_wb_t;

    typedef struct packed {
        logic        en;
        logic [3:0]  dest;
        logic [31:0] value;
    } wb_port_t;

endpackage

`default_nettype wire

// ==== decode/decode_stage.sv ====
`default_nettype none

module decode_stage
    import arm_isa_pkg::*;
    import arm_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        freeze,
    input  logic        flush,
    input  logic [31:0] if_pc,
    input  instr_u      if_instr,
    input  logic [3:0]  status,     // {N, Z, C, V}.
    input  wb_port_t    wb,
    output logic [3:0]  src1,
    output logic [3:0]  src2,
    output logic        two_src,
    output id_ex_t      id_ex
);

    logic        is_dp;
    logic        is_mem;
    logic        is_br;
    logic        uses_rn;
    logic        cond_ok;
    logic        wb_en;
    logic        mem_r_en;
    logic        mem_w_en;
    logic        s;
    exe_cmd_e    exe_cmd;
    logic [31:0] val_rn;
    logic [31:0] val_rm;

    register_file u_regfile (
        .clk    (clk),
        .rst    (rst),
        .src1   (src1),
        .src2   (src2),
        .wb     (wb),
        .val_rn (val_rn),
        .val_rm (val_rm)
    );

    assign is_dp  = (if_instr.dp.cls == CLASS_DP);
    assign is_mem = (if_instr.dp.cls == CLASS_MEM);
    assign is_br  = (if_instr.br.cls == CLASS_BR) && !if_instr.br.link;

    always_comb begin
        case (if_instr.dp.cond)
            COND_EQ: cond_ok = status[2];
            COND_NE: cond_ok = !status[2];
            COND_AL: cond_ok = 1'b1;
            default: cond_ok = 1'b0;
        endcase
    end

    // ==========================================================
    // Control decode
    // ==========================================================
    always_comb begin
        exe_cmd  = EXE_NOP;
        wb_en    = 1'b0;
        mem_r_en = 1'b0;
        mem_w_en = 1'b0;
        if (is_dp) begin
            wb_en = 1'b1;
            case (if_instr.dp.opcode)
                OP_MOV:  exe_cmd = EXE_MOV;
                OP_MVN:  exe_cmd = EXE_MVN;
                OP_ADD:  exe_cmd = EXE_ADD;
                OP_SUB:  exe_cmd = EXE_SUB;
                OP_AND:  exe_cmd = EXE_AND;
                OP_ORR:  exe_cmd = EXE_ORR;
                OP_EOR:  exe_cmd = EXE_EOR;
                OP_CMP: begin
                    exe_cmd = EXE_SUB;
                    wb_en   = 1'b0;
                end
                default: wb_en = 1'b0;
            endcase
        end else if (is_mem) begin
            exe_cmd  = EXE_ADD;         // Base plus offset.
            mem_r_en = if_instr.dp.s;
            mem_w_en = !if_instr.dp.s;
            wb_en    = if_instr.dp.s;
        end
    end

    assign s       = is_dp && if_instr.dp.s && (exe_cmd != EXE_NOP);
    assign uses_rn = is_mem || (is_dp && if_instr.dp.opcode != OP_MOV &&
                                if_instr.dp.opcode != OP_MVN);

    // r15 is never written, so it can stand for "no source".
    assign src1    = uses_rn ? if_instr.dp.rn : 4'd15;
    assign src2    = mem_w_en ? if_instr.dp.rd : if_instr.dp.operand2[3:0];
    assign two_src = (is_dp && !if_instr.dp.i) || mem_w_en;   // STR reads Rd as data.

    // Decode/execute register.
    always_ff @(posedge clk) begin
        if (rst || flush || freeze) begin
            id_ex <= '0;    // Bubble.
        end else begin
            id_ex.pc            <= if_pc;
            id_ex.val_rn        <= val_rn;
            id_ex.val_rm        <= val_rm;
            id_ex.src1          <= src1;
            id_ex.src2          <= src2;
            id_ex.dest          <= if_instr.dp.rd;
            id_ex.exe_cmd       <= exe_cmd;
            id_ex.imm           <= if_instr.dp.i;
            id_ex.shift_operand <= if_instr.dp.operand2;
            id_ex.signed_imm_24 <= if_instr.br.imm24;
            id_ex.wb_en         <= wb_en && cond_ok;
            id_ex.mem_r_en      <= mem_r_en && cond_ok;
            id_ex.mem_w_en      <= mem_w_en && cond_ok;
            id_ex.b             <= is_br && cond_ok;
            id_ex.s             <= s && cond_ok;
        end
    end

endmodule

`default_nettype wire

// ==== decode/register_file.sv ====
`default_nettype none

module register_file
    import arm_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  src1,
    input  logic [3:0]  src2,
    input  wb_port_t    wb,
    output logic [31:0] val_rn,
    output logic [31:0] val_rm
);

    logic [31:0] regs [15];     // r0..r14.

    // Written on the falling edge, so decode reads a writeback in the same cycle.
    always_ff @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.dest != 4'd15) begin
            regs[wb.dest] <= wb.value;
        end
    end

    // r15 reads as zero.
    assign val_rn = (src1 == 4'd15) ? '0 : regs[src1];
    assign val_rm = (src2 == 4'd15) ? '0 : regs[src2];

endmodule

`default_nettype wire

// ==== design/arm_cpu.sv ====
`default_nettype none

module arm_cpu
    import arm_isa_pkg::*;
    import arm_pipe_pkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        mode,       // 0 stalls on RAW, 1 forwards.
    output logic [29:0] imem_addr,
    input  instr_u      imem_data,
    output wb_port_t    wb
);

    logic        freeze;
    logic        branch_taken;
    logic [31:0] branch_addr;
    logic [31:0] if_pc;
    instr_u      if_instr;
    logic [3:0]  status;
    logic [3:0]  src1;
    logic [3:0]  src2;
    logic        two_src;
    id_ex_t      id_ex;
    fwd_sel_e    sel_src1;
    fwd_sel_e    sel_src2;
    ex_mem_t     ex_mem;
    logic [3:0]  mem_dest;
    logic        mem_wb_en;

    fetch_stage u_fetch (
        .clk          (clk),
        .rst          (rst),
        .freeze       (freeze),
        .branch_taken (branch_taken),
        .branch_addr  (branch_addr),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .if_pc        (if_pc),
        .if_instr     (if_instr)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst      (rst),
        .freeze   (freeze),
        .flush    (branch_taken),
        .if_pc    (if_pc),
        .if_instr (if_instr),
        .status   (status),
        .wb       (wb),
        .src1     (src1),
        .src2     (src2),
        .two_src  (two_src),
        .id_ex    (id_ex)
    );

    hazard_forward_unit u_hazard (
        .mode      (mode),
        .src1      (src1),
        .src2      (src2),
        .two_src   (two_src),
        .id_ex     (id_ex),
        .mem_dest  (mem_dest),
        .mem_wb_en (mem_wb_en),
        .wb        (wb),
        .freeze    (freeze),
        .sel_src1  (sel_src1),
        .sel_src2  (sel_src2)
    );

    execute_stage u_execute (
        .clk          (clk),
        .rst          (rst),
        .id_ex        (id_ex),
        .sel_src1     (sel_src1),
        .sel_src2     (sel_src2),
        .mem_alu_res  (ex_mem.alu_res),
        .wb           (wb),
        .status       (status),
        .branch_taken (branch_taken),
        .branch_addr  (branch_addr),
        .ex_mem       (ex_mem),
        .mem_dest     (mem_dest),
        .mem_wb_en    (mem_wb_en)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory (
        .clk    (clk),
        .rst    (rst),
        .ex_mem (ex_mem),
        .wb     (wb)
    );

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`default_nettype none

module execute_stage
    import arm_isa_pkg::*;
    import arm_pipe_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  id_ex_t      id_ex,
    input  fwd_sel_e    sel_src1,
    input  fwd_sel_e    sel_src2,
    input  logic [31:0] mem_alu_res,
    input  wb_port_t    wb,
    output logic [3:0]  status,
    output logic        branch_taken,
    output logic [31:0] branch_addr,
    output ex_mem_t     ex_mem,
    output logic [3:0]  mem_dest,
    output logic        mem_wb_en
);

    logic [31:0] op1;
    logic [31:0] rm;
    logic [31:0] op2;
    logic [31:0] res;
    logic [32:0] sum;
    logic        carry;
    logic        ovf;
    logic [3:0]  flags;
    logic [3:0]  status_q;

    // ==========================================================
    // Operands
    // ==========================================================
    always_comb begin
        case (sel_src1)
            FWD_MEM: op1 = mem_alu_res;
            FWD_WB:  op1 = wb.value;
            default: op1 = id_ex.val_rn;
        endcase
        case (sel_src2)
            FWD_MEM: rm = mem_alu_res;
            FWD_WB:  rm = wb.value;
            default: rm = id_ex.val_rm;
        endcase
    end

    always_comb begin
        if (id_ex.mem_r_en || id_ex.mem_w_en) begin
            op2 = {20'd0, id_ex.shift_operand};     // 12-bit offset.
        end else if (id_ex.imm) begin
            op2 = {24'd0, id_ex.shift_operand[7:0]};
        end else begin
            op2 = rm << id_ex.shift_operand[11:7];  // LSL only.
        end
    end

    // ==========================================================
    // ALU and flags
    // ==========================================================
    always_comb begin
        sum   = '0;
        carry = status_q[1];    // Logical ops keep C and V.
        ovf   = status_q[0];
        case (id_ex.exe_cmd)
            EXE_MOV: res = op2;
            EXE_MVN: res = ~op2;
            EXE_ADD: begin
                sum   = {1'b0, op1} + {1'b0, op2};
                res   = sum[31:0];
                carry = sum[32];
                ovf   = (op1[31] == op2[31]) && (res[31] != op1[31]);
            end
            EXE_SUB: begin
                sum   = {1'b0, op1} + {1'b0, ~op2} + 33'd1;
                res   = sum[31:0];
                carry = sum[32];    // Not borrow.
                ovf   = (op1[31] != op2[31]) && (res[31] != op1[31]);
            end
            EXE_AND: res = op1 & op2;
            EXE_ORR: res = op1 | op2;
            EXE_EOR: res = op1 ^ op2;
            default: res = '0;
        endcase
    end

    assign flags = {res[31], (res == '0), carry, ovf};

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= '0;
        end else if (id_ex.s) begin
            status_q <= flags;
        end
    end

    // New flags pass straight to decode, so a branch may follow its compare.
    assign status = id_ex.s ? flags : status_q;

    assign branch_taken = id_ex.b;
    assign branch_addr  = id_ex.pc + 32'd8 +
                          {{6{id_ex.signed_imm_24[23]}}, id_ex.signed_imm_24, 2'b00};

    // Execute/memory register.
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.wb_en    <= 1'b0;
            ex_mem.mem_r_en <= 1'b0;
            ex_mem.mem_w_en <= 1'b0;
        end else begin
            ex_mem.wb_en    <= id_ex.wb_en;
            ex_mem.mem_r_en <= id_ex.mem_r_en;
            ex_mem.mem_w_en <= id_ex.mem_w_en;
        end
        ex_mem.alu_res <= res;
        ex_mem.val_rm  <= rm;
        ex_mem.dest    <= id_ex.dest;
    end

    assign mem_dest  = ex_mem.dest;
    assign mem_wb_en = ex_mem.wb_en;

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
`default_nettype none

module fetch_stage
    import arm_isa_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        freeze,
    input  logic        branch_taken,
    input  logic [31:0] branch_addr,
    output logic [29:0] imem_addr,
    input  instr_u      imem_data,
    output logic [31:0] if_pc,
    output instr_u      if_instr
);

    logic [31:0] pc;

    assign imem_addr = pc[31:2];    // Word address.

    // A redirect wins over a freeze.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_addr;
        end else if (!freeze) begin
            pc <= pc + 32'd4;
        end
    end

    // Fetch/decode register.
    always_ff @(posedge clk) begin
        if (rst || branch_taken) begin
            if_instr <= NOP_WORD;   // Wrong-path word becomes a no-op.
        end else if (!freeze) begin
            if_instr <= imem_data;
            if_pc    <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== design/hazard_forward_unit.sv ====
`default_nettype none

module hazard_forward_unit
    import arm_pipe_pkg::*;
(
    input  logic       mode,
    input  logic [3:0] src1,
    input  logic [3:0] src2,
    input  logic       two_src,
    input  id_ex_t     id_ex,
    input  logic [3:0] mem_dest,
    input  logic       mem_wb_en,
    input  wb_port_t   wb,
    output logic       freeze,
    output fwd_sel_e   sel_src1,
    output fwd_sel_e   sel_src2
);

    logic exe_hit;
    logic mem_hit;

    // Decode sources against the execute and memory destinations.
    assign exe_hit = id_ex.wb_en &&
                     (src1 == id_ex.dest || (two_src && src2 == id_ex.dest));
    assign mem_hit = mem_wb_en &&
                     (src1 == mem_dest || (two_src && src2 == mem_dest));

    // Mode 1 only waits out a load-use pair.
    assign freeze = mode ? (exe_hit && id_ex.mem_r_en) : (exe_hit || mem_hit);

    // Memory stage is the younger result and takes priority.
    always_comb begin
        sel_src1 = FWD_RF;
        sel_src2 = FWD_RF;
        if (mode) begin
            if (mem_wb_en && mem_dest == id_ex.src1) begin
                sel_src1 = FWD_MEM;
            end else if (wb.en && wb.dest == id_ex.src1) begin
                sel_src1 = FWD_WB;
            end
            if (mem_wb_en && mem_dest == id_ex.src2) begin
                sel_src2 = FWD_MEM;
            end else if (wb.en && wb.dest == id_ex.src2) begin
                sel_src2 = FWD_WB;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/memory_stage.sv ====
`default_nettype none

module memory_stage
    import arm_pipe_pkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  logic     clk,
    input  logic     rst,
    input  ex_mem_t  ex_mem,
    output wb_port_t wb
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   dmem [DMEM_WORDS];
    logic [31:0]   offset;
    logic [AW-1:0] idx;
    logic [31:0]   mem_res;
    mem_wb_t       mem_wb;

    // Data space starts at byte address 1024.
    assign offset  = ex_mem.alu_res - 32'd1024;
    assign idx     = offset[AW+1:2];
    assign mem_res = dmem[idx];     // Combinational load.

    always_ff @(posedge clk) begin
        if (ex_mem.mem_w_en) begin
            dmem[idx] <= ex_mem.val_rm;
        end
    end

    // Memory/writeback register.
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.wb_en    <= 1'b0;
            mem_wb.mem_r_en <= 1'b0;
        end else begin
            mem_wb.wb_en    <= ex_mem.wb_en;
            mem_wb.mem_r_en <= ex_mem.mem_r_en;
        end
        mem_wb.alu_res <= ex_mem.alu_res;
        mem_wb.mem_res <= mem_res;
        mem_wb.dest    <= ex_mem.dest;
    end

    assign wb.en    = mem_wb.wb_en;
    assign wb.dest  = mem_wb.dest;
    assign wb.value = mem_wb.mem_r_en ? mem_wb.mem_res : mem_wb.alu_res;

endmodule

`default_nettype wire

// ==== dv/arm_ref_model.svh ====
`ifndef ARM_REF_MODEL_SVH
`define ARM_REF_MODEL_SVH

// ============================================================
// Instruction encoders and random program generators
// ============================================================
function automatic logic [31:0] enc_dp(logic [3:0] op, logic i, logic s, logic [3:0] rn,
                                       logic [3:0] rd, logic [11:0] op2);
    return {COND_AL, CLASS_DP, i, op, s, rn, rd, op2};
endfunction

function automatic logic [31:0] enc_mem(logic load, logic [3:0] rd, logic [11:0] off);
    return {COND_AL, CLASS_MEM, 1'b0, 4'b0000, load, 4'd13, rd, off};  // Base is r13.
endfunction

function automatic logic [31:0] enc_br(logic [3:0] cond, logic [23:0] imm);
    return {cond, CLASS_BR, 1'b1, 1'b0, imm};
endfunction

function automatic logic [3:0] rand_reg(int nregs);
    return 4'($unsigned($random(seed)) % nregs);
endfunction

function automatic logic [31:0] random_dp(int nregs);
    logic [31:0] r;
    logic [3:0]  op;
    logic        i;
    logic        s;
    r = $random(seed);
    case (r[2:0])
        3'd0: op = OP_MOV;
        3'd1: op = OP_MVN;
        3'd2: op = OP_ADD;
        3'd3: op = OP_SUB;
        3'd4: op = OP_AND;
        3'd5: op = OP_ORR;
        3'd6: op = OP_EOR;
        default: op = OP_CMP;
    endcase
    i = r[3];
    s = (op == OP_CMP) ? 1'b1 : r[4];
    if (i) begin
        return enc_dp(op, i, s, rand_reg(nregs), rand_reg(nregs), {4'd0, r[15:8]});
    end
    return enc_dp(op, i, s, rand_reg(nregs), rand_reg(nregs),
                  {r[20:16], 3'b000, rand_reg(nregs)});
endfunction

// Dense register reuse over r0..r3.
task automatic gen_alu_program();
    for (int k = 0; k < 40; k++) begin
        prog[k] = random_dp(4);
    end
    prog[40] = enc_br(COND_AL, 24'hFF_FFFE);    // Branch to self.
    prog_len = 41;
endtask

task automatic gen_mem_program();
    logic [31:0] r;
    prog[0] = enc_dp(OP_MOV, 1'b1, 1'b0, 4'd0, 4'd13, 12'd1);
    prog[1] = enc_dp(OP_MOV, 1'b0, 1'b0, 4'd0, 4'd13, {5'd10, 3'b000, 4'd13});  // 1024.
    for (int k = 0; k < 8; k++) begin
        r = $random(seed);
        prog[2 + 2 * k] = enc_dp(OP_MOV, 1'b1, 1'b0, 4'd0, 4'd0, {4'd0, r[7:0]});
        prog[3 + 2 * k] = enc_mem(1'b0, 4'd0, 12'(4 * k));
    end
    for (int k = 18; k < 50; k++) begin
        r = $random(seed);
        if (r[1:0] == 2'd0) begin
            prog[k] = random_dp(4);
        end else begin
            prog[k] = enc_mem(r[2], rand_reg(4), {7'd0, r[6:4], 2'b00});
        end
    end
    prog[50] = enc_br(COND_AL, 24'hFF_FFFE);
    prog_len = 51;
endtask

task automatic gen_branch_program();
    logic [31:0] r;
    logic [3:0]  cond;
    for (int k = 0; k < 44; k++) begin
        r = $random(seed);
        case (r[1:0])
            2'd0: prog[k] = enc_dp(OP_MOV, 1'b1, r[2], 4'd0, rand_reg(4), {10'd0, r[5:4]});
            2'd1: prog[k] = enc_dp(OP_CMP, 1'b1, 1'b1, rand_reg(4), 4'd0, {10'd0, r[5:4]});
            2'd2: begin
                cond = (r[7:6] == 2'd0) ? COND_AL : (r[6] ? COND_EQ : COND_NE);
                // Offset -1..2 skips up to three words and always points forward.
                prog[k] = (k + 4 <= 44) ? enc_br(cond, 24'($signed({1'b0, r[9:8]}) - 1))
                                        : random_dp(4);
            end
            default: prog[k] = random_dp(4);
        endcase
    end
    prog[44] = enc_br(COND_AL, 24'hFF_FFFE);
    prog_len = 45;
endtask

// ============================================================
// Instruction-level reference model
// ============================================================
task automatic run_model();
    logic [31:0] mregs [16];
    logic [31:0] mmem [64];
    logic [31:0] w;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] res;
    logic [31:0] addr;
    logic        z;
    logic        taken;
    logic        done;
    int          pc;
    int          steps;
    int          target;
    for (int k = 0; k < 16; k++) begin
        mregs[k] = '0;
    end
    for (int k = 0; k < 64; k++) begin
        mmem[k] = '0;
    end
    exp_dest.delete();
    exp_val.delete();
    z     = 1'b0;
    pc    = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 1000) begin
        w = prog[pc];
        steps++;
        if (w[27:26] == 2'b00) begin
            op1 = mregs[w[19:16]];
            op2 = w[25] ? {24'd0, w[7:0]} : (mregs[w[3:0]] << w[11:7]);
            case (w[24:21])
                OP_MOV: res = op2;
                OP_MVN: res = ~op2;
                OP_AND: res = op1 & op2;
                OP_ORR: res = op1 | op2;
                OP_EOR: res = op1 ^ op2;
                OP_ADD: res = op1 + op2;
                default: res = op1 - op2;     // SUB and CMP.
            endcase
            if (w[20]) begin
                z = (res == 32'd0);
            end
            if (w[24:21] != OP_CMP) begin
                mregs[w[15:12]] = res;
                exp_dest.push_back(w[15:12]);
                exp_val.push_back(res);
            end
            pc++;
        end else if (w[27:26] == 2'b01) begin
            addr = mregs[w[19:16]] + {20'd0, w[11:0]};
            if (w[20]) begin
                mregs[w[15:12]] = mmem[addr[7:2]];
                exp_dest.push_back(w[15:12]);
                exp_val.push_back(mmem[addr[7:2]]);
            end else begin
                mmem[addr[7:2]] = mregs[w[15:12]];
            end
            pc++;
        end else begin
            taken  = (w[31:28] == COND_AL) || (w[31:28] == COND_EQ && z) ||
                     (w[31:28] == COND_NE && !z);
            target = pc + 2 + $signed({{8{w[23]}}, w[23:0]});
            if (taken && target == pc) begin
                done = 1'b1;
            end else begin
                pc = taken ? target : pc + 1;
            end
        end
    end
endtask

`endif

// ==== dv/tb_arm_cpu.sv ====
`default_nettype none

module tb_arm_cpu
    import arm_isa_pkg::*;
    import arm_pipe_pkg::*;
;

    logic        clk;
    logic        rst;
    logic        mode;
    logic [29:0] imem_addr;
    instr_u      imem_data;
    wb_port_t    wb;

    logic [31:0] imem [256];
    logic [31:0] prog [64];
    int          prog_len;
    logic [3:0]  exp_dest [$];
    logic [31:0] exp_val [$];
    integer      seed;
    int          errors;
    int          tests;
    int          test_cycles;
    int          cycle_limit;
    logic        counting;
    string       test_name;

    `include "arm_ref_model.svh"

    arm_cpu #(
        .DMEM_WORDS (64)
    ) DUT (
        .clk       (clk),
        .rst       (rst),
        .mode      (mode),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb        (wb)
    );

    always #4 clk = ~clk;

    // Words past the array read as never-executed no-ops.
    assign imem_data = (imem_addr < 30'd256) ? imem[imem_addr[7:0]]
                                             : {4'hF, imem_addr[27:0]};

    always @(posedge clk) begin
        test_cycles <= counting ? test_cycles + 1 : 0;
    end

    initial begin : watchdog
        wait (counting && test_cycles > cycle_limit);
        $display("Timeout in test %s: expected writes not reached", test_name);
        $display("** FAIL **");
        $finish;
    end

    task automatic run_test(input string name, input logic m);
        int got;
        int errs_before;
        int tail;
        errs_before = errors;
        test_name   = name;
        for (int k = 0; k < 256; k++) begin
            imem[k] = {4'hF, 28'(k)};   // NV-condition fill.
        end
        for (int k = 0; k < prog_len; k++) begin
            imem[k] = prog[k];
        end
        run_model();
        @(posedge clk);
        rst  <= 1'b1;
        mode <= m;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (imem_addr == 30'd0) else begin
            $display("Error: imem_addr after reset got %h expected %h", imem_addr, 30'd0);
            errors++;
        end
        assert (!wb.en) else begin
            $display("Error: wb.en after reset got %h expected %h", wb.en, 1'b0);
            errors++;
        end
        cycle_limit = 8 * prog_len + 20;
        counting    = 1'b1;
        got         = 0;
        while (got < exp_dest.size()) begin
            if (wb.en) begin
                assert (wb.dest == exp_dest[got]) else begin
                    $display("Error: wb.dest got %h expected %h", wb.dest, exp_dest[got]);
                    errors++;
                end
                assert (wb.value == exp_val[got]) else begin
                    $display("Error: wb.value got %h expected %h", wb.value, exp_val[got]);
                    errors++;
                end
                got++;
            end
            @(negedge clk);
        end
        // Nothing may retire once the final branch is fetched and the pipeline drains.
        tail = 0;
        while (tail < 12) begin
            assert (!wb.en) else begin
                $display("Test %s: unexpected register write to r%0d after the last one",
                         name, wb.dest);
                errors++;
            end
            if (tail > 0 || imem_addr == 30'(prog_len - 1)) begin
                tail++;
            end
            @(negedge clk);
        end
        counting = 1'b0;
        tests++;
        $display("Test %s: %0d writes, %0d errors", name, got, errors - errs_before);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        mode        = 1'b0;
        seed        = 32'h93ab;
        errors      = 0;
        tests       = 0;
        counting    = 1'b0;
        cycle_limit = 1000;
        test_name   = "none";
        gen_alu_program();
        run_test("alu_mode0", 1'b0);
        run_test("alu_mode1", 1'b1);
        gen_mem_program();
        run_test("mem_mode0", 1'b0);
        run_test("mem_mode1", 1'b1);
        gen_branch_program();
        run_test("branch_mode0", 1'b0);
        run_test("branch_mode1", 1'b1);
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+dv
common/arm_isa_pkg.sv
common/arm_pipe_pkg.sv
decode/register_file.sv
decode/decode_stage.sv
design/fetch_stage.sv
design/hazard_forward_unit.sv
design/execute_stage.sv
design/memory_stage.sv
design/arm_cpu.sv
dv/tb_arm_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_arm_cpu -o sim_arm_cpu
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

out=$(./obj_dir/sim_arm_cpu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q '^\*\* PASS \*\*$'; then
    exit 0
fi
exit 1
